// ==== list.f ====
hdl/csr_pkg.sv
hdl/csr_wr_if.sv
hdl/csr_wr_decode.sv
hdl/csr_rw_reg.sv
hdl/mstatus_reg.sv
hdl/csr_read_mux.sv
hdl/csr_file.sv
dv/csr_file_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module csr_file_tb -o csr_file_sim
if ./obj_dir/csr_file_sim | tee /dev/stderr | grep -q "TEST OK"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== dv/csr_file_tb.sv ====
`timescale 1ns/1ps

module csr_file_tb;
    import csr_pkg::*;

    typedef struct packed {
        logic        en;
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [2:0]  irq;
        logic        exp_illegal;
    } row_t;

    // Every implemented CSR plus two unimplemented addresses
    localparam logic [11:0] all_addrs [16] = '{
        mvendorid_addr, marchid_addr, mimpid_addr, mhartid_addr, mstatus_addr, misa_addr,
        mie_addr, mtvec_addr, mcounteren_addr, mscratch_addr, mepc_addr, mcause_addr,
        mtval_addr, mip_addr, 12'h7c0, 12'h345};
    localparam logic [11:0] op_addrs [4] = '{mscratch_addr, mepc_addr, mcause_addr, mtval_addr};

    logic        clk;
    logic        rst_n;
    logic        wr_en;
    csr_op_e     wr_op;
    logic [11:0] wr_addr;
    logic [31:0] wr_data;
    logic [11:0] rd_addr;
    logic [31:0] rd_data;
    logic        irq_sw;
    logic        irq_timer;
    logic        irq_ext;
    logic        illegal_wr;
    logic        irq_pending;

    row_t        rows[$];
    logic [31:0] model_mem [4096];

    csr_file #(.hart_id(32'h0), .vendor_id(32'h0)) i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Writable bits per address, zero for anything not writable
    function automatic logic [31:0] write_mask(input logic [11:0] addr);
        case (addr)
            mstatus_addr: return 32'h0000_0088;
            mie_addr: return 32'h0000_0888;
            mepc_addr: return 32'hffff_fffc;
            mscratch_addr, mcause_addr, mtval_addr: return 32'hffff_ffff;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] expected_read(input logic [11:0] addr, input logic [2:0] irq);
        case (addr)
            mvendorid_addr, mhartid_addr: return 32'h0;
            marchid_addr: return marchid_val;
            mimpid_addr: return mimpid_val;
            misa_addr: return misa_val;
            mtvec_addr: return mtvec_val;
            mcounteren_addr: return mcounteren_val;
            mip_addr: return {20'h0, irq[2], 3'b0, irq[1], 3'b0, irq[0], 3'b0};
            default: return model_mem[addr];
        endcase
    endfunction

    function automatic logic expected_pending(input logic [2:0] irq);
        return model_mem[mstatus_addr][3] &&
               (|(expected_read(mip_addr, irq) & model_mem[mie_addr]));
    endfunction

    task automatic model_write(input csr_op_e op, input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] next;
        case (op)
            csr_op_set: next = model_mem[addr] | data;
            csr_op_clear: next = model_mem[addr] & ~data;
            default: next = data;
        endcase
        model_mem[addr] = next & write_mask(addr);
        // MPP hardwired to machine mode
        if (addr == mstatus_addr)
            model_mem[addr][12:11] = 2'b11;
    endtask

    task automatic add_row(input logic en, input csr_op_e op, input logic [11:0] addr,
                           input logic [31:0] data, input logic [2:0] irq, input logic exp_illegal);
        row_t r;
        r = '{en, op, addr, data, irq, exp_illegal};
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] mie_vals [5] = '{32'h8, 32'h80, 32'h800, 32'h888, 32'h0};
        foreach (all_addrs[i])
            add_row(1'b0, csr_op_write, all_addrs[i], 32'h0, 3'b0, 1'b0);
        foreach (op_addrs[i])
        begin
            add_row(1'b1, csr_op_write, op_addrs[i], $urandom, 3'b0, 1'b0);
            add_row(1'b1, csr_op_set, op_addrs[i], $urandom, 3'b0, 1'b0);
            add_row(1'b1, csr_op_clear, op_addrs[i], $urandom, 3'b0, 1'b0);
        end
        add_row(1'b1, csr_op_write, mepc_addr, 32'hffff_ffff, 3'b0, 1'b0);
        add_row(1'b1, csr_op_write, mie_addr, 32'hffff_ffff, 3'b0, 1'b0);
        add_row(1'b1, csr_op_write, mstatus_addr, 32'hffff_ffff, 3'b0, 1'b0);
        add_row(1'b1, csr_op_clear, mstatus_addr, 32'h0000_0008, 3'b0, 1'b0);
        add_row(1'b1, csr_op_write, mstatus_addr, 32'h0, 3'b0, 1'b0);
        // Read-only and unimplemented targets
        add_row(1'b1, csr_op_write, mvendorid_addr, 32'hffff_ffff, 3'b0, 1'b1);
        add_row(1'b1, csr_op_set, misa_addr, 32'hffff_ffff, 3'b0, 1'b1);
        add_row(1'b1, csr_op_write, 12'h7c0, $urandom, 3'b0, 1'b1);
        add_row(1'b1, csr_op_clear, mip_addr, 32'hffff_ffff, 3'b0, 1'b1);
        foreach (all_addrs[i])
            add_row(1'b0, csr_op_write, all_addrs[i], 32'h0, 3'b0, 1'b0);
        // Every irq level under each mie pattern, global enable off then on
        for (int s = 0; s < 2; s++)
        begin
            add_row(1'b1, csr_op_write, mstatus_addr, 32'(s) << 3, 3'b0, 1'b0);
            foreach (mie_vals[m])
            begin
                add_row(1'b1, csr_op_write, mie_addr, mie_vals[m], 3'b0, 1'b0);
                for (int q = 0; q < 8; q++)
                    add_row(1'b0, csr_op_write, mip_addr, 32'h0, 3'(q), 1'b0);
            end
        end
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk);
        wr_en <= r.en;
        wr_op <= r.op;
        wr_addr <= r.addr;
        wr_data <= r.data;
        rd_addr <= r.addr;
        {irq_ext, irq_timer, irq_sw} <= r.irq;
        @(negedge clk);
        check({31'h0, illegal_wr}, {31'h0, r.exp_illegal}, $sformatf("illegal_wr at %h", r.addr));
        check(rd_data, expected_read(r.addr, r.irq), $sformatf("read of %h", r.addr));
        check({31'h0, irq_pending}, {31'h0, expected_pending(r.irq)}, "irq_pending");
        if (r.en && write_mask(r.addr) != 32'h0)
            model_write(r.op, r.addr, r.data);
        @(posedge clk);
        wr_en <= 1'b0;
        @(negedge clk);
        check(rd_data, expected_read(r.addr, r.irq), $sformatf("read back of %h", r.addr));
        check({31'h0, irq_pending}, {31'h0, expected_pending(r.irq)}, "irq_pending after write");
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1)
        begin
            if (cycles == 20)
            begin
                $display("Timeout: reset still asserted after %0d cycles", cycles);
                $display("TEST FAILED");
                $fatal(1, "reset timeout");
            end
            else
            begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'h5fdf650f));
        wr_en = 1'b0;
        wr_op = csr_op_write;
        wr_addr = 12'h0;
        wr_data = 32'h0;
        rd_addr = 12'h0;
        irq_sw = 1'b0;
        irq_timer = 1'b0;
        irq_ext = 1'b0;
        model_mem = '{default: 32'h0};
        model_mem[mstatus_addr] = 32'h0000_1800;
        wait_reset_release();
        build_table();
        foreach (rows[i])
            apply_row(rows[i]);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== hdl/csr_file.sv ====
`timescale 1ns/1ps

module csr_file
    import csr_pkg::*;
#(
    parameter logic [31:0] hart_id = 32'h0,
    parameter logic [31:0] vendor_id = 32'h0
)
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  csr_op_e     wr_op,
    input  logic [11:0] wr_addr,
    input  logic [31:0] wr_data,
    input  logic [11:0] rd_addr,
    output logic [31:0] rd_data,
    input  logic        irq_sw,
    input  logic        irq_timer,
    input  logic        irq_ext,
    output logic        illegal_wr,
    output logic        irq_pending
);

    logic [num_rw_csrs-1:0]       slot_we;
    logic                         mstatus_we;
    logic [num_rw_csrs-1:0][31:0] rw_values;
    csr_word_u                    mstatus;

    csr_wr_if wr_bus ();

    assign wr_bus.en = wr_en;
    assign wr_bus.op = wr_op;
    assign wr_bus.addr = wr_addr;
    assign wr_bus.data = wr_data;

    csr_wr_decode i_wr_decode (
        .wr         (wr_bus.decode),
        .slot_we    (slot_we),
        .mstatus_we (mstatus_we),
        .illegal_wr (illegal_wr)
    );

    mstatus_reg i_mstatus (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr_bus.regs),
        .we      (mstatus_we),
        .mstatus (mstatus)
    );

    // One slot per table entry, mask and reset from the package
    for (genvar i = 0; i < num_rw_csrs; i++)
    begin : g_rw_csr
        csr_rw_reg #(
            .mask        (rw_csr_mask[i]),
            .reset_value (rw_csr_reset[i])
        ) i_csr (
            .clk   (clk),
            .rst_n (rst_n),
            .wr    (wr_bus.regs),
            .we    (slot_we[i]),
            .value (rw_values[i])
        );
    end

    csr_read_mux #(
        .hart_id   (hart_id),
        .vendor_id (vendor_id)
    ) i_read_mux (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rw_values   (rw_values),
        .mstatus     (mstatus),
        .irq_sw      (irq_sw),
        .irq_timer   (irq_timer),
        .irq_ext     (irq_ext),
        .irq_pending (irq_pending)
    );

endmodule

// ==== hdl/csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux
    import csr_pkg::*;
#(
    parameter logic [31:0] hart_id = 32'h0,
    parameter logic [31:0] vendor_id = 32'h0
)
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [11:0]                   rd_addr,
    output logic [31:0]                   rd_data,
    input  logic [num_rw_csrs-1:0][31:0] rw_values,
    input  csr_word_u                     mstatus,
    input  logic                          irq_sw,
    input  logic                          irq_timer,
    input  logic                          irq_ext,
    output logic                          irq_pending
);

    logic [31:0] mip;

    // MSIP, MTIP, MEIP follow the input levels
    always_comb
    begin
        mip = 32'h0;
        mip[3] = irq_sw;
        mip[7] = irq_timer;
        mip[11] = irq_ext;
    end

    assign irq_pending = mstatus.f.mie && (|(mip & rw_values[mie_slot]));

    always_comb
    begin
        rd_data = 32'h0;
        case (rd_addr)
            mvendorid_addr:  rd_data = vendor_id;
            marchid_addr:    rd_data = marchid_val;
            mimpid_addr:     rd_data = mimpid_val;
            mhartid_addr:    rd_data = hart_id;
            mstatus_addr:    rd_data = mstatus.raw;
            misa_addr:       rd_data = misa_val;
            mtvec_addr:      rd_data = mtvec_val;
            mcounteren_addr: rd_data = mcounteren_val;
            mip_addr:        rd_data = mip;
            default:
            begin
                // Writable slots, anything else reads zero
                for (int i = 0; i < num_rw_csrs; i++)
                begin
                    if (rd_addr == rw_csr_addr[i])
                        rd_data = rw_values[i];
                end
            end
        endcase
    end

    // Catches an unreset register or a floating irq input reaching the bus
    a_rd_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(rd_data))
    else
        $error("csr_read_mux: unknown read data at addr %h", rd_addr);

endmodule

// ==== hdl/mstatus_reg.sv ====
`timescale 1ns/1ps

module mstatus_reg
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    csr_wr_if.regs    wr,
    input  logic      we,
    output csr_word_u mstatus
);

    csr_word_u candidate;
    csr_word_u legal;

    always_comb
    begin
        // Raw view for the bit operations
        case (wr.op)
            csr_op_write: candidate.raw = wr.data;
            csr_op_set:   candidate.raw = mstatus.raw | wr.data;
            csr_op_clear: candidate.raw = mstatus.raw & ~wr.data;
            default:      candidate.raw = mstatus.raw;
        endcase

        // Field view for WARL
        legal.raw = 32'h0;
        legal.f.mie = candidate.f.mie;
        legal.f.mpie = candidate.f.mpie;
        legal.f.mpp = machine_mode;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mstatus.raw <= 32'h0;
            mstatus.f.mpp <= machine_mode;
        end
        else if (we)
        begin
            mstatus <= legal;
        end
    end

    // Only machine mode exists
    a_mpp_machine: assert property (@(posedge clk) disable iff (!rst_n)
        mstatus.f.mpp == machine_mode)
    else
        $error("mstatus_reg: MPP left machine mode, mstatus %h", mstatus.raw);

endmodule

// ==== hdl/csr_rw_reg.sv ====
`timescale 1ns/1ps

module csr_rw_reg
    import csr_pkg::*;
#(
    parameter logic [31:0] mask = 32'hffff_ffff,
    parameter logic [31:0] reset_value = 32'h0
)
(
    input  logic        clk,
    input  logic        rst_n,
    csr_wr_if.regs      wr,
    input  logic        we,
    output logic [31:0] value
);

    logic [31:0] candidate;

    always_comb
    begin
        case (wr.op)
            csr_op_write: candidate = wr.data;
            csr_op_set:   candidate = value | wr.data;
            csr_op_clear: candidate = value & ~wr.data;
            default:      candidate = value;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            value <= reset_value & mask;
        else if (we)
            value <= candidate & mask;
    end

    // WARL bits stay zero across reset and every operation
    a_masked_bits_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (value & ~mask) == 32'h0)
    else
        $error("csr_rw_reg: bits outside mask set, value %h", value);

endmodule

// ==== hdl/csr_wr_decode.sv ====
`timescale 1ns/1ps

module csr_wr_decode
    import csr_pkg::*;
(
    csr_wr_if.decode               wr,
    output logic [num_rw_csrs-1:0] slot_we,
    output logic                   mstatus_we,
    output logic                   illegal_wr
);

    logic [num_rw_csrs-1:0] slot_hit;
    logic                   mstatus_hit;
    logic                   read_only;
    logic                   known;

    always_comb
    begin
        for (int i = 0; i < num_rw_csrs; i++)
        begin
            slot_hit[i] = (wr.addr == rw_csr_addr[i]);
        end
        mstatus_hit = (wr.addr == mstatus_addr);

        slot_we = slot_hit & {num_rw_csrs{wr.en}};
        mstatus_we = mstatus_hit && wr.en;

        // Top two address bits set means read-only space
        read_only = (wr.addr[11:10] == 2'b11);
        // Constant and derived CSRs fall out here as well
        known = mstatus_hit || (|slot_hit);
        illegal_wr = wr.en && (read_only || !known);

        // Duplicate entries in the slot table would break this
        assert ($onehot0({slot_we, mstatus_we}))
        else
            $error("csr_wr_decode: more than one write enable for addr %h", wr.addr);
    end

endmodule

// ==== hdl/csr_wr_if.sv ====
`timescale 1ns/1ps

interface csr_wr_if
    import csr_pkg::*;
();

    logic        en;
    csr_op_e     op;
    logic [11:0] addr;
    logic [31:0] data;

    // Address side, seen by the decoder
    modport decode (input en, input addr);

    // Data side, seen by the registers
    modport regs (input op, input data);

endinterface

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

    localparam logic [1:0] machine_mode = 2'b11;

    // Machine information, read-only
    localparam logic [11:0] mvendorid_addr = 12'hf11;
    localparam logic [11:0] marchid_addr = 12'hf12;
    localparam logic [11:0] mimpid_addr = 12'hf13;
    localparam logic [11:0] mhartid_addr = 12'hf14;

    // Trap setup
    localparam logic [11:0] mstatus_addr = 12'h300;
    localparam logic [11:0] misa_addr = 12'h301;
    localparam logic [11:0] mie_addr = 12'h304;
    localparam logic [11:0] mtvec_addr = 12'h305;
    localparam logic [11:0] mcounteren_addr = 12'h306;

    // Trap handling
    localparam logic [11:0] mscratch_addr = 12'h340;
    localparam logic [11:0] mepc_addr = 12'h341;
    localparam logic [11:0] mcause_addr = 12'h342;
    localparam logic [11:0] mtval_addr = 12'h343;
    localparam logic [11:0] mip_addr = 12'h344;

    // Low two bits of funct3 for CSRRW, CSRRS and CSRRC
    typedef enum logic [1:0] {
        csr_op_write = 2'b01,
        csr_op_set   = 2'b10,
        csr_op_clear = 2'b11
    } csr_op_e;

    typedef struct packed {
        logic [18:0] rsvd_31_13;
        logic [1:0]  mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_fields_t;

    typedef union packed {
        logic [31:0]     raw;
        mstatus_fields_t f;
    } csr_word_u;

    // Generic writable slots, mie first
    localparam int num_rw_csrs = 5;
    localparam int mie_slot = 0;

    localparam logic [11:0] rw_csr_addr [num_rw_csrs] =
        '{mie_addr, mscratch_addr, mepc_addr, mcause_addr, mtval_addr};
    // mie holds MSIE, MTIE, MEIE only; mepc is word aligned
    localparam logic [31:0] rw_csr_mask [num_rw_csrs] =
        '{32'h0000_0888, 32'hffff_ffff, 32'hffff_fffc, 32'hffff_ffff, 32'hffff_ffff};
    localparam logic [31:0] rw_csr_reset [num_rw_csrs] = '{default: 32'h0};

    localparam logic [31:0] marchid_val = 32'h0000_0000;
    localparam logic [31:0] mimpid_val = 32'h0000_0000;
    // MXL = 32 bit, I extension
    localparam logic [31:0] misa_val = 32'h4000_0100;
    localparam logic [31:0] mtvec_val = 32'h0000_0100;
    localparam logic [31:0] mcounteren_val = 32'h0000_0000;

endpackage
